/* Bender.yml */
package:
  name: fm_pg

sources:
  - files:
      - src/fm_pkg.sv
      - src/fm_delay_line.sv
      - src/fm_slot_counter.sv
      - src/fm_apb_regs.sv
      - src/fm_phase_gen.sv
      - src/fm_pg_top.sv
  - target: test
    files:
      - dv/fm_clk_gen.sv
      - dv/fm_tb.sv

/* build.f */
src/fm_pkg.sv
src/fm_delay_line.sv
src/fm_slot_counter.sv
src/fm_apb_regs.sv
src/fm_phase_gen.sv
src/fm_pg_top.sv
dv/fm_clk_gen.sv
dv/fm_tb.sv

/* dv/fm_clk_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock, 4 ns period, reset high for the first 16 cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fm_clk_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Released on a rising edge like any other driven input
	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

/* dv/fm_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Directed tests for the FM phase generator with cen held high
// Expected phases come from a model of the increment and detune rules
// Outputs are sampled on the falling edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fm_tb;

	// Stage I to pg_out
	localparam int PIPE_LATENCY = 7;

	logic clk;
	logic reset;
	fm_pkg::apb_req_t apb_req;
	fm_pkg::apb_rsp_t apb_rsp;
	fm_pkg::pg_out_t pg_out;

	logic [31:0] rng_state = 32'h1584;
	logic [9:0] got [2][128];
	logic [9:0] round_ph [3][fm_pkg::N_SLOTS];
	string cur_test;
	int errors;
	int checks;
	int tests_run;
	int errs_at_start;

	fm_clk_gen u_clk_gen (
		.clk   (clk),
		.reset (reset)
	);

	fm_pg_top dut0 (
		.clk     (clk),
		.reset   (reset),
		.cen     (1'b1),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.pg_out  (pg_out)
	);

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic int phase_increment(input int fnum, input int block,
			input int mul, input int dt1);
		int inc;
		int keycode;
		int top3;
		int index;
		int pow2;
		int offset;
		int limit;
		inc = (fnum << block) >> 1;
		top3 = (fnum >> 7) & 7;
		keycode = block * 4 + ((fnum >> 10) & 1) * 2;
		if ((fnum >> 10) & 1) begin
			keycode = keycode + ((top3 != 0) ? 1 : 0);
		end else begin
			keycode = keycode + ((top3 == 7) ? 1 : 0);
		end
		case (dt1 % 4)
			1: index = keycode - 4;
			2: index = keycode + 4;
			3: index = keycode + 8;
			default: index = keycode;
		endcase
		index = (index + 64) % 64;
		case (index % 8)
			0: pow2 = 16;
			1: pow2 = 17;
			2: pow2 = 19;
			3: pow2 = 20;
			4: pow2 = 22;
			5: pow2 = 24;
			6: pow2 = 26;
			default: pow2 = 29;
		endcase
		if (index / 8 <= 4) begin
			offset = pow2 >> (4 - index / 8);
		end else if (index / 8 == 5) begin
			offset = pow2 * 2;
		end else begin
			offset = 0;
		end
		case (dt1 % 4)
			2: limit = 16;
			3: limit = 22;
			default: limit = 8;
		endcase
		if (offset > limit) begin
			offset = limit;
		end
		if (dt1 % 4 != 0) begin
			inc = (dt1 < 4) ? inc + offset : inc - offset;
			inc = (inc + 131072) % 131072;
		end
		// Multiplier zero means half
		if (mul == 0) begin
			inc = inc / 2;
		end else begin
			inc = (inc * mul) % 131072;
		end
		return inc;
	endfunction

	// Upper 10 bits of the 20 bit phase after n increments
	function automatic logic [9:0] phase_after(input int inc, input int n);
		longint p;
		p = (longint'(n) * inc) % 1048576;
		return 10'(p >> 10);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and bookkeeping

	task automatic check(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks = checks + 1;
		if (expected !== actual) begin
			errors = errors + 1;
			$display("FAIL %s %s: expected 0x%0h, actual 0x%0h", cur_test, what,
				expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		errs_at_start = errors;
		tests_run = tests_run + 1;
	endtask

	task automatic end_test();
		$display("test %s finished with %0d errors", cur_test, errors - errs_at_start);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB driver

	task automatic apb_transfer(input logic write, input int addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int waited;
		@(posedge clk);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= write;
		apb_req.paddr <= 12'(addr);
		apb_req.pwdata <= wdata;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!apb_rsp.pready && waited < 16) begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (!apb_rsp.pready) begin
			errors = errors + 1;
			$display("APB access to 0x%0h never got pready", addr);
		end
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		// Access completes on this edge
		@(posedge clk);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic apb_write(input int addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input int addr, output logic [31:0] data, output logic err);
		apb_transfer(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic read_expect_error(input int addr);
		logic [31:0] data;
		logic err;
		apb_read(addr, data, err);
		check($sformatf("pslverr at 0x%0h", addr), 1, err);
	endtask

	task automatic configure_slot(input int s, input int fnum, input int block,
			input int mul, input int dt1);
		logic err;
		apb_write(s * 8 + fm_pkg::REG_FREQ_OFS, (block << 11) | fnum, err);
		check("frequency write pslverr", 0, err);
		apb_write(s * 8 + fm_pkg::REG_OP_OFS, (dt1 << 4) | mul, err);
		check("operator write pslverr", 0, err);
	endtask

	// Outputs of visits before the key-on drain out first
	task automatic key_on(input int s);
		logic err;
		apb_write(fm_pkg::REG_KEYON, s, err);
		check("key-on pslverr", 0, err);
		repeat (PIPE_LATENCY) @(posedge clk);
	endtask

	task automatic write_ctrl(input logic stop);
		logic err;
		apb_write(fm_pkg::REG_CTRL, {31'd0, stop}, err);
		check("control write pslverr", 0, err);
		repeat (PIPE_LATENCY) @(posedge clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitors

	task automatic slot_phases(input int sel, input int s, input int k);
		int n;
		int waited;
		n = 0;
		waited = 0;
		while (n < k && waited < k * fm_pkg::N_SLOTS + 64) begin
			@(negedge clk);
			waited = waited + 1;
			if (pg_out.valid && pg_out.slot == s) begin
				got[sel][n] = pg_out.phase;
				n = n + 1;
			end
		end
		if (n < k) begin
			errors = errors + 1;
			$display("Slot %0d produced only %0d of %0d outputs in time", s, n, k);
		end
	endtask

	task automatic expect_phases(input int sel, input int s, input int k,
			input int inc, input int first);
		slot_phases(sel, s, k);
		for (int j = 0; j < k; j++) begin
			check($sformatf("slot %0d visit %0d", s, j), phase_after(inc, first + j),
				got[sel][j]);
		end
	endtask

	task automatic capture_round(input int r);
		int n;
		int waited;
		n = 0;
		waited = 0;
		while (n < fm_pkg::N_SLOTS && waited < fm_pkg::N_SLOTS + 16) begin
			@(negedge clk);
			waited = waited + 1;
			if (pg_out.valid) begin
				round_ph[r][pg_out.slot] = pg_out.phase;
				n = n + 1;
			end
		end
		if (n < fm_pkg::N_SLOTS) begin
			errors = errors + 1;
			$display("Round %0d saw only %0d valid outputs", r, n);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	// Valid stays low while the pipeline fills and then stays high
	task automatic output_fill();
		int n;
		start_test("output_fill");
		n = 1;
		@(negedge clk);
		while (!pg_out.valid && n < 64) begin
			@(negedge clk);
			n = n + 1;
		end
		check("enabled cycles until valid", PIPE_LATENCY, n);
		check("first output slot", 0, pg_out.slot);
		for (int i = 0; i < 2 * fm_pkg::N_SLOTS; i++) begin
			@(negedge clk);
			check("valid after fill", 1, pg_out.valid);
		end
		end_test();
	endtask

	task automatic register_access();
		int slots [6];
		logic [31:0] fw [6];
		logic [31:0] ow [6];
		logic [31:0] data;
		logic err;
		start_test("register_access");
		for (int i = 0; i < 6; i++) begin
			slots[i] = i * 4 + next_rand() % 4;
			fw[i] = next_rand();
			ow[i] = next_rand();
			apb_write(slots[i] * 8 + fm_pkg::REG_FREQ_OFS, fw[i], err);
			check("frequency write pslverr", 0, err);
			apb_write(slots[i] * 8 + fm_pkg::REG_OP_OFS, ow[i], err);
			check("operator write pslverr", 0, err);
		end
		for (int i = 0; i < 6; i++) begin
			apb_read(slots[i] * 8 + fm_pkg::REG_FREQ_OFS, data, err);
			check($sformatf("slot %0d frequency word", slots[i]),
				fw[i] & 32'h3fff, data);
			apb_read(slots[i] * 8 + fm_pkg::REG_OP_OFS, data, err);
			check($sformatf("slot %0d operator word", slots[i]),
				ow[i] & 32'h7f, data);
		end
		read_expect_error(12'h0c0);
		read_expect_error(12'h0fc);
		read_expect_error(12'h002);
		read_expect_error(12'h108);
		read_expect_error(12'h800);
		apb_write(fm_pkg::REG_KEYON, 30, err);
		check("key-on slot 30 pslverr", 1, err);
		apb_write(fm_pkg::REG_KEYON, 24, err);
		check("key-on slot 24 pslverr", 1, err);
		apb_read(fm_pkg::REG_KEYON, data, err);
		check("key-on read data", 0, data);
		check("key-on read pslverr", 0, err);
		apb_read(fm_pkg::REG_CTRL, data, err);
		check("control read data", 0, data);
		end_test();
	endtask

	task automatic plain_accumulation();
		int fnum;
		int block;
		int mul;
		start_test("plain_accumulation");
		for (int r = 0; r < 2; r++) begin
			fnum = next_rand() % 2048;
			block = next_rand() % 8;
			mul = 1 + next_rand() % 15;
			configure_slot(5 + r * 15, fnum, block, mul, 0);
			key_on(5 + r * 15);
			expect_phases(0, 5 + r * 15, 8, phase_increment(fnum, block, mul, 0), 0);
		end
		end_test();
	endtask

	task automatic multiplier_zero();
		int fnum;
		int block;
		start_test("multiplier_zero");
		for (int r = 0; r < 2; r++) begin
			fnum = (r == 0) ? 2047 : next_rand() % 2048;
			block = (r == 0) ? 7 : next_rand() % 8;
			configure_slot(9, fnum, block, 0, 0);
			key_on(9);
			expect_phases(0, 9, 6, phase_increment(fnum, block, 0, 0), 0);
		end
		end_test();
	endtask

	// Keycodes 0, 4, 15, 21 and 31
	// Keycode 0 wraps below zero and keycode 4 lands on index zero
	task automatic detune_offsets();
		int fnum;
		int block;
		start_test("detune");
		for (int c = 0; c < 5; c++) begin
			case (c)
				0: begin
					fnum = 12'h000;
					block = 0;
				end
				1: begin
					fnum = 12'h2c3;
					block = 1;
				end
				2: begin
					fnum = 12'h480;
					block = 3;
				end
				3: begin
					fnum = 12'h3ff;
					block = 5;
				end
				default: begin
					fnum = 12'h7ff;
					block = 7;
				end
			endcase
			for (int dt1 = 0; dt1 < 8; dt1++) begin
				configure_slot(12, fnum, block, 15, dt1);
				key_on(12);
				expect_phases(0, 12, 72,
					phase_increment(fnum, block, 15, dt1), 0);
			end
		end
		end_test();
	endtask

	task automatic keyon_and_stop();
		int inc_a;
		int inc_b;
		logic [31:0] f;
		logic [31:0] data;
		logic err;
		start_test("keyon_and_stop");
		f = next_rand();
		configure_slot(3, f % 2048, (f >> 11) % 8, (f >> 14) % 16, (f >> 18) % 8);
		inc_a = phase_increment(f % 2048, (f >> 11) % 8, (f >> 14) % 16, (f >> 18) % 8);
		f = next_rand();
		configure_slot(17, f % 2048, (f >> 11) % 8, 1 + (f >> 14) % 15, 0);
		inc_b = phase_increment(f % 2048, (f >> 11) % 8, 1 + (f >> 14) % 15, 0);
		key_on(17);
		// Slot 3 is reset mid-run while slot 17 keeps counting
		fork
			expect_phases(0, 17, 6, inc_b, 0);
			begin
				repeat (30) @(posedge clk);
				key_on(3);
				expect_phases(1, 3, 3, inc_a, 0);
			end
		join
		write_ctrl(1'b1);
		for (int r = 0; r < 3; r++) begin
			capture_round(r);
		end
		for (int r = 1; r < 3; r++) begin
			for (int s = 0; s < fm_pkg::N_SLOTS; s++) begin
				check($sformatf("slot %0d held in round %0d", s, r), round_ph[0][s],
					round_ph[r][s]);
			end
		end
		apb_read(fm_pkg::REG_CTRL, data, err);
		check("stop bit read back", 1, data);
		// Key-on still clears while stopped and the phase then holds at zero
		key_on(17);
		expect_phases(0, 17, 2, 0, 0);
		write_ctrl(1'b0);
		expect_phases(0, 17, 4, inc_b, 1);
		end_test();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int waited;
		apb_req = '0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		waited = 0;
		@(posedge clk);
		while (reset !== 1'b0 && waited < 64) begin
			@(posedge clk);
			waited = waited + 1;
		end
		if (reset !== 1'b0) begin
			errors = errors + 1;
			$display("Reset was never released");
		end
		output_fill();
		register_access();
		plain_accumulation();
		multiplier_zero();
		detune_offsets();
		keyon_and_stop();
		$display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/fm_apb_regs.sv */
////////////////////////////////////////////////////////////////////////////
// APB slave with per-slot configuration, key-on and stop control
// No wait states and writes land at the end of the access phase
// Bad addresses and key-on slots of 24 or more give pslverr and have no effect
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fm_apb_regs (
	input  wire              clk,
	input  wire              reset,
	input  wire fm_pkg::apb_req_t apb_req,
	output fm_pkg::apb_rsp_t apb_rsp,
	input  wire fm_pkg::slot_t    slot,
	input  wire              slot_advance,
	output fm_pkg::pg_cfg_t  cfg,
	output logic             pg_rst,
	output logic             pg_stop
);

	fm_pkg::pg_cfg_t cfg_mem [fm_pkg::N_SLOTS];
	logic [fm_pkg::N_SLOTS-1:0] keyon_pend;
	logic stop;

	logic access;
	logic in_window;
	logic hit_freq;
	logic hit_op;
	logic hit_ctrl;
	logic hit_keyon;
	logic keyon_ok;
	logic slv_err;
	logic wr_en;
	fm_pkg::slot_t acc_slot;
	fm_pkg::slot_t keyon_slot;
	fm_pkg::reg_word_u wr_word;
	fm_pkg::reg_word_u rd_word;

	////////////////////////////////////////////////////////////////////////////
	// Address decode

	always_comb begin
		access = apb_req.psel & apb_req.penable;
		acc_slot = apb_req.paddr[7:3];
		in_window = (apb_req.paddr[11:8] == 4'd0) && (apb_req.paddr[7:3] < fm_pkg::N_SLOTS);
		hit_freq = in_window && (apb_req.paddr[2:0] == fm_pkg::REG_FREQ_OFS);
		hit_op = in_window && (apb_req.paddr[2:0] == fm_pkg::REG_OP_OFS);
		hit_ctrl = (apb_req.paddr == fm_pkg::REG_CTRL);
		hit_keyon = (apb_req.paddr == fm_pkg::REG_KEYON);

		wr_word = fm_pkg::reg_word_u'(apb_req.pwdata);
		keyon_ok = (apb_req.pwdata < fm_pkg::N_SLOTS);
		keyon_slot = apb_req.pwdata[fm_pkg::SLOT_WIDTH-1:0];

		slv_err = access & (~(hit_freq | hit_op | hit_ctrl | hit_keyon)
			| (apb_req.pwrite & hit_keyon & ~keyon_ok));
		wr_en = access & apb_req.pwrite & ~slv_err;
	end

	// Response with key-on reading back as zero
	always_comb begin
		rd_word = '0;
		if (hit_freq) begin
			rd_word.freq.fnum = cfg_mem[acc_slot].fnum;
			rd_word.freq.block = cfg_mem[acc_slot].block;
		end else if (hit_op) begin
			rd_word.op.mul = cfg_mem[acc_slot].mul;
			rd_word.op.dt1 = cfg_mem[acc_slot].dt1;
		end
		apb_rsp.pready = 1'b1;
		apb_rsp.pslverr = slv_err;
		if (access && !apb_req.pwrite) begin
			apb_rsp.prdata = hit_ctrl ? {31'd0, stop} : rd_word;
		end else begin
			apb_rsp.prdata = '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Register state

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < fm_pkg::N_SLOTS; i++) begin
				cfg_mem[i] <= '0;
			end
			keyon_pend <= '0;
			stop <= 1'b0;
		end else begin
			// Pending key-on is consumed when its slot is presented
			if (slot_advance) begin
				keyon_pend[slot] <= 1'b0;
			end
			if (wr_en) begin
				if (hit_freq) begin
					cfg_mem[acc_slot].fnum <= wr_word.freq.fnum;
					cfg_mem[acc_slot].block <= wr_word.freq.block;
				end
				if (hit_op) begin
					cfg_mem[acc_slot].mul <= wr_word.op.mul;
					cfg_mem[acc_slot].dt1 <= wr_word.op.dt1;
				end
				if (hit_ctrl) begin
					stop <= apb_req.pwdata[0];
				end
				// A fresh request wins over the clear above
				if (hit_keyon) begin
					keyon_pend[keyon_slot] <= 1'b1;
				end
			end
		end
	end

	// Current slot view for the pipeline
	assign cfg = cfg_mem[slot];
	assign pg_rst = keyon_pend[slot];
	assign pg_stop = stop;

endmodule

`default_nettype wire

/* src/fm_delay_line.sv */
////////////////////////////////////////////////////////////////////////////
// Clock enabled shift register, stages must be 2 or more
// Whole line is cleared by reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fm_delay_line #(
	parameter int width  = 1,
	parameter int stages = 2
) (
	input  wire              clk,
	input  wire              reset,
	input  wire              cen,
	input  wire [width-1:0]  din,
	output logic [width-1:0] dout
);

	logic [stages-1:0][width-1:0] sh;

	// New sample enters at index 0
	always_ff @(posedge clk) begin
		if (reset) begin
			sh <= '0;
		end else if (cen) begin
			sh <= {sh[stages-2:0], din};
		end
	end

	assign dout = sh[stages-1];

endmodule

`default_nettype wire

/* src/fm_pg_top.sv */
////////////////////////////////////////////////////////////////////////////
// FM phase generator top, 24 slots with APB configuration
// pg_out is valid for one clock per enabled cycle, no back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fm_pg_top (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   cen,
	input  wire fm_pkg::apb_req_t apb_req,
	output fm_pkg::apb_rsp_t      apb_rsp,
	output fm_pkg::pg_out_t       pg_out
);

	fm_pkg::slot_t slot;
	fm_pkg::pg_cfg_t cfg;
	logic pg_rst;
	logic pg_stop;

	fm_slot_counter u_slot_counter (
		.clk       (clk),
		.reset     (reset),
		.cen       (cen),
		.slot      (slot),
		.slot_zero ()
	);

	// Register file, key-on is consumed on each enabled slot
	fm_apb_regs u_apb_regs (
		.clk          (clk),
		.reset        (reset),
		.apb_req      (apb_req),
		.apb_rsp      (apb_rsp),
		.slot         (slot),
		.slot_advance (cen),
		.cfg          (cfg),
		.pg_rst       (pg_rst),
		.pg_stop      (pg_stop)
	);

	fm_phase_gen u_phase_gen (
		.clk     (clk),
		.reset   (reset),
		.cen     (cen),
		.slot    (slot),
		.cfg     (cfg),
		.pg_rst  (pg_rst),
		.pg_stop (pg_stop),
		.pg_out  (pg_out)
	);

endmodule

`default_nettype wire

/* src/fm_phase_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Eight stage phase increment and accumulation pipeline
// All slot inputs are sampled at stage I, output appears 7 cycles later
// No LFO phase modulation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fm_phase_gen (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  cen,
	input  wire fm_pkg::slot_t   slot,
	input  wire fm_pkg::pg_cfg_t cfg,
	input  wire                  pg_rst,
	input  wire                  pg_stop,
	output fm_pkg::pg_out_t      pg_out
);

	localparam int IW = fm_pkg::PH_INC_WIDTH;
	localparam int TAG_W = fm_pkg::SLOT_WIDTH + 1;

	logic [IW:0]   fnum_shl;
	logic [IW-1:0] phinc_ii, phinc_iii, phinc_iv, phinc_v, phinc_vi;
	logic [4:0]    keycode_ii;
	logic [2:0]    dt1_ii, dt1_iii, dt1_iv;
	logic [3:0]    mul_ii, mul_iii, mul_iv, mul_v;
	logic          stop_ii, stop_iii, stop_iv, stop_v, stop_vi;
	logic [5:0]    dt1_kf_iii;
	logic [4:0]    pow2;
	logic [5:0]    dt1_unlimited;
	logic [4:0]    dt1_limit;
	logic [4:0]    dt1_offset_iv;
	logic [IW+3:0] phinc_prod;
	logic          pg_rst_vi;
	logic [fm_pkg::PH_WIDTH-1:0] phase_drop, phase_in;
	logic [fm_pkg::PH_OUT_WIDTH-1:0] phase_vii, phase_viii;
	logic [TAG_W-1:0] tag_viii;

	////////////////////////////////////////////////////////////////////////////
	// I  block shift and keycode

	assign fnum_shl = {7'd0, cfg.fnum} << cfg.block;

	always_ff @(posedge clk) begin
		if (reset) begin
			phinc_ii <= '0;
			keycode_ii <= '0;
			dt1_ii <= '0;
			mul_ii <= '0;
			stop_ii <= 1'b0;
		end else if (cen) begin
			phinc_ii <= fnum_shl[IW:1];
			keycode_ii <= {cfg.block, cfg.fnum[10],
				cfg.fnum[10] ? (|cfg.fnum[9:7]) : (&cfg.fnum[9:7])};
			dt1_ii <= cfg.dt1;
			mul_ii <= cfg.mul;
			stop_ii <= pg_stop;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// II  detune index, wraps modulo 64

	always_ff @(posedge clk) begin
		if (reset) begin
			dt1_kf_iii <= '0;
			phinc_iii <= '0;
			dt1_iii <= '0;
			mul_iii <= '0;
			stop_iii <= 1'b0;
		end else if (cen) begin
			case (dt1_ii[1:0])
				2'd1: dt1_kf_iii <= {1'b0, keycode_ii} - 6'd4;
				2'd2: dt1_kf_iii <= {1'b0, keycode_ii} + 6'd4;
				2'd3: dt1_kf_iii <= {1'b0, keycode_ii} + 6'd8;
				default: dt1_kf_iii <= {1'b0, keycode_ii};
			endcase
			phinc_iii <= phinc_ii;
			dt1_iii <= dt1_ii;
			mul_iii <= mul_ii;
			stop_iii <= stop_ii;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// III  offset table and clamp

	always_comb begin
		case (dt1_kf_iii[2:0])
			3'd0: pow2 = 5'd16;
			3'd1: pow2 = 5'd17;
			3'd2: pow2 = 5'd19;
			3'd3: pow2 = 5'd20;
			3'd4: pow2 = 5'd22;
			3'd5: pow2 = 5'd24;
			3'd6: pow2 = 5'd26;
			default: pow2 = 5'd29;
		endcase
		// High index bits scale the power, top two octaves give zero
		case (dt1_kf_iii[5:3])
			3'd0: dt1_unlimited = {5'd0, pow2[4]};
			3'd1: dt1_unlimited = {4'd0, pow2[4:3]};
			3'd2: dt1_unlimited = {3'd0, pow2[4:2]};
			3'd3: dt1_unlimited = {2'd0, pow2[4:1]};
			3'd4: dt1_unlimited = {1'd0, pow2};
			3'd5: dt1_unlimited = {pow2, 1'b0};
			default: dt1_unlimited = 6'd0;
		endcase
		case (dt1_iii[1:0])
			2'd2: dt1_limit = 5'd16;
			2'd3: dt1_limit = 5'd22;
			default: dt1_limit = 5'd8;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dt1_offset_iv <= '0;
			phinc_iv <= '0;
			dt1_iv <= '0;
			mul_iv <= '0;
			stop_iv <= 1'b0;
		end else if (cen) begin
			dt1_offset_iv <= (dt1_unlimited > {1'b0, dt1_limit}) ? dt1_limit : dt1_unlimited[4:0];
			phinc_iv <= phinc_iii;
			dt1_iv <= dt1_iii;
			mul_iv <= mul_iii;
			stop_iv <= stop_iii;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// IV  apply offset, V  multiply

	assign phinc_prod = phinc_v * mul_v;

	always_ff @(posedge clk) begin
		if (reset) begin
			phinc_v <= '0;
			mul_v <= '0;
			stop_v <= 1'b0;
			phinc_vi <= '0;
			stop_vi <= 1'b0;
		end else if (cen) begin
			if (dt1_iv[1:0] == 2'd0) begin
				phinc_v <= phinc_iv;
			end else if (!dt1_iv[2]) begin
				phinc_v <= phinc_iv + {12'd0, dt1_offset_iv};
			end else begin
				phinc_v <= phinc_iv - {12'd0, dt1_offset_iv};
			end
			mul_v <= mul_iv;
			stop_v <= stop_iv;
			// Multiplier zero halves the increment
			phinc_vi <= (mul_v == 4'd0) ? {1'b0, phinc_v[IW-1:1]} : phinc_prod[IW-1:0];
			stop_vi <= stop_v;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// VI  accumulate, VII and VIII output registers

	assign phase_in = pg_rst_vi ? '0 : (stop_vi ? phase_drop : phase_drop + {3'd0, phinc_vi});

	always_ff @(posedge clk) begin
		if (reset) begin
			phase_vii <= '0;
			phase_viii <= '0;
		end else if (cen) begin
			phase_vii <= phase_in[fm_pkg::PH_WIDTH-1 -: fm_pkg::PH_OUT_WIDTH];
			phase_viii <= phase_vii;
		end
	end

	// Phase of each slot circulates once per round
	fm_delay_line #(.width(fm_pkg::PH_WIDTH), .stages(fm_pkg::N_SLOTS)) u_phase_loop (
		.clk   (clk),
		.reset (reset),
		.cen   (cen),
		.din   (phase_in),
		.dout  (phase_drop)
	);

	fm_delay_line #(.width(1), .stages(5)) u_rst_line (
		.clk   (clk),
		.reset (reset),
		.cen   (cen),
		.din   (pg_rst),
		.dout  (pg_rst_vi)
	);

	// Slot tag plus fill flag, flag is zero until the pipeline has filled
	fm_delay_line #(.width(TAG_W), .stages(7)) u_tag_line (
		.clk   (clk),
		.reset (reset),
		.cen   (cen),
		.din   ({1'b1, slot}),
		.dout  (tag_viii)
	);

	assign pg_out.valid = tag_viii[TAG_W-1] & cen;
	assign pg_out.slot = tag_viii[TAG_W-2:0];
	assign pg_out.phase = phase_viii;

endmodule

`default_nettype wire

/* src/fm_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared types and constants for the FM phase generator
// Slot windows are 8 bytes wide, word aligned, 24 slots from address 0
// Control registers sit above the slot windows at 0x100 and 0x104
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package fm_pkg;

	// Slot sequencing
	localparam int N_SLOTS = 24;
	localparam int SLOT_WIDTH = 5;

	typedef logic [SLOT_WIDTH-1:0] slot_t;

	// Phase widths
	localparam int PH_WIDTH = 20;
	localparam int PH_OUT_WIDTH = 10;
	localparam int PH_INC_WIDTH = 17;

	// APB bus widths
	localparam int APB_AW = 12;
	localparam int APB_DW = 32;

	////////////////////////////////////////////////////////////////////////////
	// Register map

	localparam logic [2:0] REG_FREQ_OFS = 3'h0;
	localparam logic [2:0] REG_OP_OFS = 3'h4;
	localparam logic [APB_AW-1:0] REG_CTRL = 12'h100;
	localparam logic [APB_AW-1:0] REG_KEYON = 12'h104;

	// One slot's configuration
	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [3:0]  mul;
		logic [2:0]  dt1;
	} pg_cfg_t;

	// Frequency view of the data word
	typedef struct packed {
		logic [17:0] rsvd;
		logic [2:0]  block;
		logic [10:0] fnum;
	} freq_word_t;

	// Operator view of the data word
	typedef struct packed {
		logic [24:0] rsvd;
		logic [2:0]  dt1;
		logic [3:0]  mul;
	} op_word_t;

	typedef union packed {
		freq_word_t freq;
		op_word_t   op;
	} reg_word_u;

	////////////////////////////////////////////////////////////////////////////
	// Bus and output bundles

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic                    valid;
		slot_t                   slot;
		logic [PH_OUT_WIDTH-1:0] phase;
	} pg_out_t;

endpackage

`default_nettype wire

/* src/fm_slot_counter.sv */
////////////////////////////////////////////////////////////////////////////
// Operator slot counter, 0 to 23 on enabled cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module fm_slot_counter (
	input  wire           clk,
	input  wire           reset,
	input  wire           cen,
	output fm_pkg::slot_t slot,
	output logic          slot_zero
);

	localparam fm_pkg::slot_t LAST_SLOT = fm_pkg::slot_t'(fm_pkg::N_SLOTS - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= '0;
		end else if (cen) begin
			if (slot == LAST_SLOT) begin
				slot <= '0;
			end else begin
				slot <= slot + 1'b1;
			end
		end
	end

	// Start of a round
	assign slot_zero = (slot == '0);

endmodule

`default_nettype wire
